/* common/zap_pkg.sv */
`default_nettype none

package zap_pkg;

        localparam int DATA_W    = 32;
        localparam int REG_IDX_W = 4;

        localparam logic [REG_IDX_W-1:0] PC_REG = 4'd15;

        // Flag positions in the status word.
        localparam int FLAG_N = 31;
        localparam int FLAG_Z = 30;
        localparam int FLAG_C = 29;
        localparam int FLAG_V = 28;

        typedef enum logic [3:0] {
                OP_AND, OP_EOR, OP_SUB, OP_RSB,
                OP_ADD, OP_ADC, OP_SBC, OP_RSC,
                OP_TST, OP_TEQ, OP_CMP, OP_CMN,
                OP_ORR, OP_MOV, OP_BIC, OP_MVN
        } alu_op_t;

        // RORI rotates the 8-bit immediate.
        typedef enum logic [2:0] {
                SH_LSL, SH_LSR, SH_ASR, SH_ROR, SH_RORI
        } shift_op_t;

        typedef enum logic [1:0] {
                KIND_NOP, KIND_DATA_PROC, KIND_LOAD, KIND_STORE
        } instr_kind_t;

        typedef struct packed {
                instr_kind_t            kind;
                logic [3:0]             cond;
                alu_op_t                alu_op;
                logic                   set_flags;
                logic [REG_IDX_W-1:0]   rn;
                logic [REG_IDX_W-1:0]   rd;
                logic [REG_IDX_W-1:0]   rm;
                logic                   use_imm;
                logic [11:0]            imm12;
                shift_op_t              shift_op;
                logic [4:0]             shift_amt;
                logic                   up;             // Add the offset.
                logic [DATA_W-1:0]      pc_plus_8;
        } decoded_t;

        typedef struct packed {
                logic [DATA_W-1:0]      rn_value;
                logic [DATA_W-1:0]      rm_value;
                logic [DATA_W-1:0]      rd_value;
        } operands_t;

        typedef struct packed {
                logic                   valid;
                logic                   load;
                logic [REG_IDX_W-1:0]   index;
                logic [DATA_W-1:0]      data;
        } wb_t;

        typedef struct packed {
                logic                   read_en;
                logic                   write_en;
                logic [DATA_W-1:0]      address;
                logic [DATA_W-1:0]      wr_data;
        } mem_req_t;

endpackage

`default_nettype wire

/* rtl/zap_register_file.sv */
`timescale 1ns/10ps
`default_nettype none

module zap_register_file import zap_pkg::*; (
        input  wire                     i_clk,
        input  wire                     i_reset,
        input  wire [REG_IDX_W-1:0]     i_rd_index_0,
        input  wire [REG_IDX_W-1:0]     i_rd_index_1,
        input  wire [REG_IDX_W-1:0]     i_rd_index_2,
        input  wire wb_t                i_wb,
        output logic [DATA_W-1:0]       o_rd_data_0,
        output logic [DATA_W-1:0]       o_rd_data_1,
        output logic [DATA_W-1:0]       o_rd_data_2
);

logic [DATA_W-1:0] regs [2**REG_IDX_W];

always_ff @(posedge i_clk) begin
        if (i_reset) begin
                for (int i = 0; i < 2**REG_IDX_W; i++)
                        regs[i] <= '0;
        end else if (i_wb.valid && i_wb.index != PC_REG) begin
                regs[i_wb.index] <= i_wb.data;  // R15 writes are dropped.
        end
end

assign o_rd_data_0 = regs[i_rd_index_0];
assign o_rd_data_1 = regs[i_rd_index_1];
assign o_rd_data_2 = regs[i_rd_index_2];

endmodule

`default_nettype wire

/* execute/zap_shifter.sv */
`timescale 1ns/10ps
`default_nettype none

module zap_shifter import zap_pkg::*; (
        input  wire decoded_t           i_decoded,
        input  wire operands_t          i_operands,
        input  wire                     i_carry,
        output logic [DATA_W-1:0]       o_value,
        output logic                    o_carry
);

logic [DATA_W-1:0]      src;
logic [4:0]             amt;
logic [2*DATA_W-1:0]    rot;

always_comb begin
        src = (i_decoded.shift_op == SH_RORI) ? {24'd0, i_decoded.imm12[7:0]}
                                              : i_operands.rm_value;
        amt = i_decoded.shift_amt;
        rot = {src, src} >> amt;

        o_value = src;
        o_carry = i_carry;

        case (i_decoded.shift_op)
        SH_LSL: begin
                if (amt != 5'd0) begin
                        o_value = src << amt;
                        o_carry = src[5'd0 - amt];
                end
        end
        SH_LSR: begin
                o_value = (amt == 5'd0) ? '0 : src >> amt;      // #0 means #32.
                o_carry = src[amt - 5'd1];
        end
        SH_ASR: begin
                if (amt == 5'd0)
                        o_value = {DATA_W{src[DATA_W-1]}};
                else
                        o_value = $signed(src) >>> amt;
                o_carry = src[amt - 5'd1];
        end
        SH_ROR: begin
                if (amt == 5'd0) begin
                        o_value = {i_carry, src[DATA_W-1:1]};   // RRX.
                        o_carry = src[0];
                end else begin
                        o_value = rot[DATA_W-1:0];
                        o_carry = src[amt - 5'd1];
                end
        end
        SH_RORI: begin
                o_value = rot[DATA_W-1:0];
                if (amt != 5'd0)
                        o_carry = rot[DATA_W-1];
        end
        default: ;
        endcase
end

endmodule

`default_nettype wire

/* execute/zap_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module zap_alu import zap_pkg::*; (
        input  wire                     i_clk,
        input  wire                     i_reset,
        input  wire                     i_data_stall,
        input  wire                     i_stall,
        input  wire decoded_t           i_decoded,
        input  wire operands_t          i_operands,
        output logic                    o_shift_carry_in,
        output wb_t                     o_x_wb,
        output mem_req_t                o_mem_req,
        output logic [DATA_W-1:0]       o_flags
);

logic [DATA_W-1:0]      op2;
logic                   shift_carry;
logic [DATA_W-1:0]      x;
logic [DATA_W-1:0]      y;
logic                   cin;
logic                   is_arith;
logic [DATA_W:0]        sum;
logic [DATA_W-1:0]      result;
logic [3:0]             nzcv;
logic                   pass;
wb_t                    wb_nxt;
mem_req_t               req_nxt;

function automatic logic cond_pass(input logic [3:0] cond, input logic [DATA_W-1:0] f);
        logic n;
        logic z;
        logic c;
        logic v;
        n = f[FLAG_N];
        z = f[FLAG_Z];
        c = f[FLAG_C];
        v = f[FLAG_V];
        case (cond)
        4'h0: return z;
        4'h1: return !z;
        4'h2: return c;
        4'h3: return !c;
        4'h4: return n;
        4'h5: return !n;
        4'h6: return v;
        4'h7: return !v;
        4'h8: return c && !z;           // HI.
        4'h9: return !c || z;
        4'hA: return n == v;            // GE.
        4'hB: return n != v;
        4'hC: return !z && (n == v);
        4'hD: return z || (n != v);
        4'hE: return 1'b1;
        default: return 1'b0;           // NV never executes.
        endcase
endfunction

assign o_shift_carry_in = o_flags[FLAG_C];

zap_shifter u_zap_shifter (
        .i_decoded      (i_decoded),
        .i_operands     (i_operands),
        .i_carry        (o_shift_carry_in),
        .o_value        (op2),
        .o_carry        (shift_carry)
);

always_comb begin
        x        = i_operands.rn_value;
        y        = op2;
        is_arith = 1'b1;
        case (i_decoded.alu_op)
        OP_SUB, OP_SBC, OP_CMP: y = ~op2;
        OP_RSB, OP_RSC: begin
                x = op2;
                y = ~i_operands.rn_value;
        end
        OP_ADD, OP_ADC, OP_CMN: ;
        default: is_arith = 1'b0;
        endcase

        case (i_decoded.alu_op)
        OP_SUB, OP_RSB, OP_CMP: cin = 1'b1;
        OP_ADC, OP_SBC, OP_RSC: cin = o_flags[FLAG_C];
        default: cin = 1'b0;
        endcase

        sum = {1'b0, x} + {1'b0, y} + {{DATA_W{1'b0}}, cin};

        case (i_decoded.alu_op)
        OP_AND, OP_TST: result = i_operands.rn_value & op2;
        OP_EOR, OP_TEQ: result = i_operands.rn_value ^ op2;
        OP_ORR:         result = i_operands.rn_value | op2;
        OP_MOV:         result = op2;
        OP_BIC:         result = i_operands.rn_value & ~op2;
        OP_MVN:         result = ~op2;
        default:        result = sum[DATA_W-1:0];
        endcase

        nzcv[3] = result[DATA_W-1];
        nzcv[2] = (result == '0);
        nzcv[1] = is_arith ? sum[DATA_W] : shift_carry;
        nzcv[0] = is_arith ? (x[DATA_W-1] == y[DATA_W-1]) && (sum[DATA_W-1] != x[DATA_W-1])
                           : o_flags[FLAG_V];

        // A stalled issue slot goes in as a bubble.
        pass = cond_pass(i_decoded.cond, o_flags) && !i_stall;

        wb_nxt           = '0;
        wb_nxt.index     = i_decoded.rd;
        wb_nxt.data      = result;
        req_nxt          = '0;
        req_nxt.address  = i_decoded.up ? i_operands.rn_value + {20'd0, i_decoded.imm12}
                                        : i_operands.rn_value - {20'd0, i_decoded.imm12};
        req_nxt.wr_data  = i_operands.rd_value;

        if (pass) begin
                case (i_decoded.kind)
                KIND_DATA_PROC: wb_nxt.valid = !(i_decoded.alu_op inside
                                                 {OP_TST, OP_TEQ, OP_CMP, OP_CMN});
                KIND_LOAD: begin
                        wb_nxt.valid     = 1'b1;
                        wb_nxt.load      = 1'b1;
                        req_nxt.read_en  = 1'b1;
                end
                KIND_STORE: req_nxt.write_en = 1'b1;
                default: ;
                endcase
        end
end

always_ff @(posedge i_clk) begin
        if (i_reset) begin
                o_x_wb    <= '0;
                o_mem_req <= '0;
                o_flags   <= '0;
        end else if (!i_data_stall) begin
                o_x_wb    <= wb_nxt;
                o_mem_req <= req_nxt;
                if (pass && i_decoded.kind == KIND_DATA_PROC && i_decoded.set_flags)
                        o_flags[FLAG_N:FLAG_V] <= nzcv;
        end
end

endmodule

`default_nettype wire

/* decode/zap_fetch_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module zap_fetch_decode import zap_pkg::*; (
        input  wire                     i_clk,
        input  wire                     i_reset,
        input  wire [DATA_W-1:0]        i_instruction,
        input  wire                     i_valid,
        input  wire                     i_data_stall,
        input  wire                     i_stall,
        output logic [DATA_W-1:0]       o_pc,
        output decoded_t                o_decoded
);

decoded_t       dec;
logic           hold;
logic           is_data_proc;
logic           is_word_xfer;

assign hold = i_data_stall | i_stall;

// Register shifts, multiplies and status transfers fall out as NOPs.
assign is_data_proc = (i_instruction[27:26] == 2'b00) &&
                      (i_instruction[25] || !i_instruction[4]) &&
                      !(i_instruction[24:23] == 2'b10 && !i_instruction[20]);

// Immediate offset, pre-indexed, word, no writeback.
assign is_word_xfer = (i_instruction[27:25] == 3'b010) && i_instruction[24] &&
                      (i_instruction[22:21] == 2'b00);

always_comb begin
        dec           = '0;
        dec.cond      = i_instruction[31:28];
        dec.alu_op    = alu_op_t'(i_instruction[24:21]);
        dec.set_flags = i_instruction[20];
        dec.rn        = i_instruction[19:16];
        dec.rd        = i_instruction[15:12];
        dec.rm        = i_instruction[3:0];
        dec.use_imm   = i_instruction[25];
        dec.imm12     = i_instruction[11:0];
        dec.up        = i_instruction[23];
        dec.pc_plus_8 = o_pc + 32'd8;

        if (i_instruction[25]) begin
                dec.shift_op  = SH_RORI;
                dec.shift_amt = {i_instruction[11:8], 1'b0};  // Twice the rotate field.
        end else begin
                dec.shift_op  = shift_op_t'({1'b0, i_instruction[6:5]});
                dec.shift_amt = i_instruction[11:7];
        end

        if (is_data_proc)
                dec.kind = KIND_DATA_PROC;
        else if (is_word_xfer)
                dec.kind = i_instruction[20] ? KIND_LOAD : KIND_STORE;
end

always_ff @(posedge i_clk) begin
        if (i_reset) begin
                o_pc      <= '0;
                o_decoded <= '0;
        end else if (!hold) begin
                if (i_valid) begin
                        o_pc      <= o_pc + 32'd4;
                        o_decoded <= dec;
                end else begin
                        o_decoded.kind <= KIND_NOP;     // Fetch bubble.
                end
        end
end

endmodule

`default_nettype wire

/* rtl/zap_issue.sv */
`timescale 1ns/10ps
`default_nettype none

module zap_issue import zap_pkg::*; (
        input  wire                     i_clk,
        input  wire                     i_reset,
        input  wire decoded_t           i_decoded,
        input  wire [DATA_W-1:0]        i_rd_data_0,
        input  wire [DATA_W-1:0]        i_rd_data_1,
        input  wire [DATA_W-1:0]        i_rd_data_2,
        input  wire wb_t                i_x_wb,
        input  wire wb_t                i_m_wb,
        input  wire                     i_data_stall,
        output logic [REG_IDX_W-1:0]    o_rd_index_0,
        output logic [REG_IDX_W-1:0]    o_rd_index_1,
        output logic [REG_IDX_W-1:0]    o_rd_index_2,
        output operands_t               o_operands,
        output logic                    o_stall
);

logic reads_rn;
logic reads_rm;
logic reads_rd;
logic hazard;
logic stall_q;          // Stall already taken for this load.

function automatic logic [DATA_W-1:0] resolve(input logic [REG_IDX_W-1:0] idx,
                                              input logic [DATA_W-1:0] rf_value);
        if (idx == PC_REG)
                return i_decoded.pc_plus_8;
        if (i_x_wb.valid && !i_x_wb.load && i_x_wb.index == idx)
                return i_x_wb.data;
        if (i_m_wb.valid && i_m_wb.index == idx)
                return i_m_wb.data;
        return rf_value;
endfunction

assign o_rd_index_0 = i_decoded.rn;
assign o_rd_index_1 = i_decoded.rm;
assign o_rd_index_2 = i_decoded.rd;

always_comb begin
        o_operands.rn_value = resolve(i_decoded.rn, i_rd_data_0);
        o_operands.rm_value = resolve(i_decoded.rm, i_rd_data_1);
        o_operands.rd_value = resolve(i_decoded.rd, i_rd_data_2);

        reads_rn = (i_decoded.kind != KIND_NOP) &&
                   !(i_decoded.kind == KIND_DATA_PROC &&
                     (i_decoded.alu_op == OP_MOV || i_decoded.alu_op == OP_MVN));
        reads_rm = (i_decoded.kind == KIND_DATA_PROC) && !i_decoded.use_imm;
        reads_rd = (i_decoded.kind == KIND_STORE);

        hazard = i_x_wb.valid && i_x_wb.load &&
                 ((reads_rn && i_decoded.rn == i_x_wb.index) ||
                  (reads_rm && i_decoded.rm == i_x_wb.index) ||
                  (reads_rd && i_decoded.rd == i_x_wb.index));
end

assign o_stall = hazard & ~stall_q;

always_ff @(posedge i_clk) begin
        if (i_reset)
                stall_q <= 1'b0;
        else if (!i_data_stall)
                stall_q <= o_stall;
end

endmodule

`default_nettype wire

/* rtl/zap_memory.sv */
`timescale 1ns/10ps
`default_nettype none

module zap_memory import zap_pkg::*; (
        input  wire                     i_clk,
        input  wire                     i_reset,
        input  wire                     i_data_stall,
        input  wire wb_t                i_x_wb,
        input  wire [DATA_W-1:0]        i_rd_data,
        output wb_t                     o_m_wb
);

// Read data is valid on the edge that ends the stall.
always_ff @(posedge i_clk) begin
        if (i_reset) begin
                o_m_wb <= '0;
        end else if (!i_data_stall) begin
                o_m_wb <= i_x_wb;
                if (i_x_wb.load)
                        o_m_wb.data <= i_rd_data;       // Load data from memory.
        end
end

endmodule

`default_nettype wire

/* rtl/zap_top.sv */
`timescale 1ns/10ps
`default_nettype none

module zap_top import zap_pkg::*; (
        input  wire                     i_clk,
        input  wire                     i_reset,
        input  wire [DATA_W-1:0]        i_instruction,
        input  wire                     i_valid,
        input  wire                     i_data_stall,
        input  wire [DATA_W-1:0]        i_rd_data,
        output wire                     o_read_en,
        output wire                     o_write_en,
        output wire [DATA_W-1:0]        o_address,
        output wire [DATA_W-1:0]        o_wr_data,
        output wire [DATA_W-1:0]        o_pc,
        output wire [DATA_W-1:0]        o_cpsr
);

decoded_t               decoded;
operands_t              operands;
wb_t                    x_wb;
wb_t                    m_wb;
mem_req_t               mem_req;
wire                    stall_from_issue;
wire [REG_IDX_W-1:0]    rd_index_0;
wire [REG_IDX_W-1:0]    rd_index_1;
wire [REG_IDX_W-1:0]    rd_index_2;
wire [DATA_W-1:0]       rd_data_0;
wire [DATA_W-1:0]       rd_data_1;
wire [DATA_W-1:0]       rd_data_2;

assign o_read_en  = mem_req.read_en;
assign o_write_en = mem_req.write_en;
assign o_address  = mem_req.address;
assign o_wr_data  = mem_req.wr_data;

zap_fetch_decode u_zap_fetch_decode (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_instruction  (i_instruction),
        .i_valid        (i_valid),
        .i_data_stall   (i_data_stall),
        .i_stall        (stall_from_issue),
        .o_pc           (o_pc),
        .o_decoded      (decoded)
);

zap_issue u_zap_issue (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_decoded      (decoded),
        .i_rd_data_0    (rd_data_0),
        .i_rd_data_1    (rd_data_1),
        .i_rd_data_2    (rd_data_2),
        .i_x_wb         (x_wb),
        .i_m_wb         (m_wb),
        .i_data_stall   (i_data_stall),
        .o_rd_index_0   (rd_index_0),
        .o_rd_index_1   (rd_index_1),
        .o_rd_index_2   (rd_index_2),
        .o_operands     (operands),
        .o_stall        (stall_from_issue)
);

zap_alu u_zap_alu (
        .i_clk            (i_clk),
        .i_reset          (i_reset),
        .i_data_stall     (i_data_stall),
        .i_stall          (stall_from_issue),
        .i_decoded        (decoded),
        .i_operands       (operands),
        .o_shift_carry_in (),
        .o_x_wb           (x_wb),
        .o_mem_req        (mem_req),
        .o_flags          (o_cpsr)
);

zap_memory u_zap_memory (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_data_stall   (i_data_stall),
        .i_x_wb         (x_wb),
        .i_rd_data      (i_rd_data),
        .o_m_wb         (m_wb)
);

zap_register_file u_zap_regf (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_rd_index_0   (rd_index_0),
        .i_rd_index_1   (rd_index_1),
        .i_rd_index_2   (rd_index_2),
        .i_wb           (m_wb),
        .o_rd_data_0    (rd_data_0),
        .o_rd_data_1    (rd_data_1),
        .o_rd_data_2    (rd_data_2)
);

endmodule

`default_nettype wire

/* testbench/zap_tb_program.svh */
`ifndef ZAP_TB_PROGRAM_SVH
`define ZAP_TB_PROGRAM_SVH

localparam int PROG_LEN = 64;

// Each word is one ARM instruction, fetched from address 4 * index.
localparam logic [31:0] PROGRAM [PROG_LEN] = '{
        32'hE3A0CC01, 32'hE3A014FF, 32'hE3A02005, 32'hE0813002,   // r12, r1, r2, ADD
        32'hE0424001, 32'hE2625010, 32'hE1816002, 32'hE22670F0,   // SUB RSB ORR EOR
        32'hE1C78002, 32'hE1E09002, 32'hE207A03C, 32'hE58C3000,   // BIC MVN AND
        32'hE58C4004, 32'hE58C5008, 32'hE58C600C, 32'hE58C7010,
        32'hE58C8014, 32'hE58C9018, 32'hE58CA01C, 32'hE1A03202,   // LSL #4
        32'hE1B04021, 32'hE2A25000, 32'hE1A06241, 32'hE1A070E2,   // LSR #0, ADC, ASR, ROR
        32'hE1B08041, 32'hE1A09063, 32'hE2C2A001, 32'hE58C3020,   // ASR #0, RRX, SBC
        32'hE58C4024, 32'hE58C5028, 32'hE58C602C, 32'hE58C7030,
        32'hE58C8034, 32'hE58C9038, 32'hE58CA03C, 32'hE3520005,   // CMP r2, #5
        32'h03A0B001, 32'h13A0B002, 32'hE1710001, 32'h43A03007,   // CMN r1, r1
        32'h53A03008, 32'hE3120002, 32'h03A04009, 32'h13A0400A,   // TST r2, #2
        32'hE3320004, 32'h13A0500B, 32'h03A0500C, 32'hE1510002,   // TEQ, CMP r1, r2
        32'hB3A0600D, 32'h93A0600E, 32'hE58CB040, 32'hE58C3044,
        32'hE58C4048, 32'hE58C504C, 32'hE58C6050, 32'h058C6054,   // STREQ never runs
        32'hE59C1100, 32'hE0812001, 32'hE2822001, 32'hE58C2058,   // Load then use.
        32'hE59C3104, 32'hE50C3004, 32'hE28F0000, 32'hE58C005C    // Store down, PC read.
};

localparam logic [31:0] LOAD_WORD_0 = 32'h12345678;     // At 0x200.
localparam logic [31:0] LOAD_WORD_1 = 32'hCAFE000F;     // At 0x204.
localparam logic [3:0]  FINAL_NZCV  = 4'b1010;

// Name, address and data of every store, in program order.
initial begin
        add_store("add",           32'h100, 32'hFF000005);
        add_store("sub",           32'h104, 32'h01000005);
        add_store("rsb_imm",       32'h108, 32'h0000000B);
        add_store("orr",           32'h10C, 32'hFF000005);
        add_store("eor_imm",       32'h110, 32'hFF0000F5);
        add_store("bic",           32'h114, 32'hFF0000F0);
        add_store("mvn",           32'h118, 32'hFFFFFFFA);
        add_store("and_imm",       32'h11C, 32'h00000034);
        add_store("lsl_4",         32'h120, 32'h00000050);
        add_store("lsr_32",        32'h124, 32'h00000000);
        add_store("adc_carry",     32'h128, 32'h00000006);
        add_store("asr_4",         32'h12C, 32'hFFF00000);
        add_store("ror_1",         32'h130, 32'h80000002);
        add_store("asr_32",        32'h134, 32'hFFFFFFFF);
        add_store("rrx",           32'h138, 32'h80000028);
        add_store("sbc_carry",     32'h13C, 32'h00000004);
        add_store("cmp_eq",        32'h140, 32'h00000001);
        add_store("cmn_mi",        32'h144, 32'h00000007);
        add_store("tst_eq",        32'h148, 32'h00000009);
        add_store("teq_ne",        32'h14C, 32'h0000000B);
        add_store("cmp_lt",        32'h150, 32'h0000000D);
        add_store("load_use",      32'h158, 32'h2468ACF1);
        add_store("load_store",    32'h0FC, 32'hCAFE000F);
        add_store("pc_read",       32'h15C, 32'h00000100);
end

`endif

/* testbench/zap_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module zap_tb;

localparam int          CLK_PERIOD = 8;
localparam logic [31:0] NOP_WORD   = 32'hF1A00000;      // MOV r0, r0 with NV.

logic           i_clk;
logic           i_reset;
logic [31:0]    i_instruction;
logic           i_valid;
logic           i_data_stall;
logic [31:0]    i_rd_data;
wire            o_read_en;
wire            o_write_en;
wire [31:0]     o_address;
wire [31:0]     o_wr_data;
wire [31:0]     o_pc;
wire [31:0]     o_cpsr;

string          exp_name [$];
logic [31:0]    exp_addr [$];
logic [31:0]    exp_data [$];
logic [31:0]    dmem [256];
int             store_count;

task automatic add_store(input string name, input logic [31:0] addr, input logic [31:0] data);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
endtask

`include "zap_tb_program.svh"

zap_top UUT (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_instruction  (i_instruction),
        .i_valid        (i_valid),
        .i_data_stall   (i_data_stall),
        .i_rd_data      (i_rd_data),
        .o_read_en      (o_read_en),
        .o_write_en     (o_write_en),
        .o_address      (o_address),
        .o_wr_data      (o_wr_data),
        .o_pc           (o_pc),
        .o_cpsr         (o_cpsr)
);

task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Simulation FAILED");
        $fatal(1);
endtask

task automatic check(input string name, input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
                $display("FAILED %s expected %h actual %h", name, expected, actual);
                stop_run("Value mismatch.");
        end
endtask

function automatic logic [31:0] fetch_word(input logic [31:0] pc);
        int idx;
        idx = int'(pc >> 2);
        if (idx < PROG_LEN)
                return PROGRAM[idx];
        return NOP_WORD;        // Past the program.
endfunction

always #(CLK_PERIOD / 2) i_clk = ~i_clk;

// Inputs change 1 ns after the rising edge.
always @(posedge i_clk) begin
        #1;
        i_instruction = fetch_word(o_pc);
        i_rd_data     = o_read_en ? dmem[o_address[9:2]] : '0;
        i_valid       = (($urandom % 4) != 0) && (o_pc < 32'(PROG_LEN * 4));  // None past the end.
        i_data_stall  = ($urandom % 4) == 0;
end

// A store completes on the edge where the stall is low.
always @(negedge i_clk) begin
        if (!i_reset && o_write_en && !i_data_stall) begin
                if (store_count >= exp_addr.size())
                        stop_run($sformatf("Unexpected extra store to address %h.", o_address));
                check({exp_name[store_count], " address"}, exp_addr[store_count], o_address);
                check({exp_name[store_count], " data"}, exp_data[store_count], o_wr_data);
                dmem[o_address[9:2]] = o_wr_data;
                store_count++;
        end
end

initial begin
        #(CLK_PERIOD * (PROG_LEN * 20 + 3));
        stop_run("Watchdog timeout, the program did not drain.");
end

initial begin
        void'($urandom(71593));
        i_clk         = 1'b0;
        i_reset       = 1'b1;
        i_instruction = NOP_WORD;
        i_valid       = 1'b0;
        i_data_stall  = 1'b0;
        i_rd_data     = '0;
        store_count   = 0;
        for (int i = 0; i < 256; i++)
                dmem[i] = 32'hA5000000 ^ (i * 32'h00010004);    // Address-dependent fill.
        dmem[8'h80] = LOAD_WORD_0;
        dmem[8'h81] = LOAD_WORD_1;

        repeat (3) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        check("reset pc", 32'd0, o_pc);
        check("reset read_en", 32'd0, {31'd0, o_read_en});
        check("reset write_en", 32'd0, {31'd0, o_write_en});

        wait (store_count == exp_addr.size());
        @(posedge i_clk);
        #1;
        check("final nzcv", {28'd0, FINAL_NZCV}, {28'd0, o_cpsr[31:28]});
        check("final pc", 32'(PROG_LEN * 4), o_pc);
        $display("Simulation PASSED");
        $finish;
end

endmodule

`default_nettype wire

/* build.f */
+incdir+testbench
common/zap_pkg.sv
rtl/zap_register_file.sv
execute/zap_shifter.sv
execute/zap_alu.sv
decode/zap_fetch_decode.sv
rtl/zap_issue.sv
rtl/zap_memory.sv
rtl/zap_top.sv
testbench/zap_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module zap_tb

sim:
	verilator --binary --timing -f build.f --top-module zap_tb -o zap_sim
	./obj_dir/zap_sim > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
